// ==== Bender.yml ====
package:
  name: mips_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/control.sv
      - hw/alu.sv
      - hw/reg_file.sv
      - hw/cp0.sv
      - hw/mips_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/mips_core_tb.sv

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;

	typedef logic [`MIPS_XLEN-1:0] word_t;

	typedef struct packed {
		word_t      pc;
		logic       wb_en;
		logic [4:0] wb_reg;
		word_t      wb_data;
		logic       mem_write;
		logic       mem_read;
		word_t      mem_addr;
		word_t      mem_wdata;
		logic       kernel_mode;
	} step_t;

	logic       clk = 1'b0;
	logic       arst_n;
	word_t      pc, instr, mem_addr, mem_wdata, mem_rdata, wb_data;
	logic       mem_write, mem_read, wb_en, kernel_mode;
	logic [4:0] wb_reg;

	word_t imem [64];
	logic  imem_used [64];
	word_t dmem [64];
	step_t steps [$];

	// architectural state as the instruction rules predict it while the table is built.
	word_t      model_regs [32];
	word_t      model_pc;
	logic       model_km;
	word_t      model_epc;
	logic [4:0] model_cause;

	logic [31:0] lfsr_state = 32'h5fc11357;
	int          cycle_count = 0;
	int          cycle_limit = 20;

	mips_core mips_core_inst (
		.clk, .arst_n, .pc, .instr, .mem_addr, .mem_wdata, .mem_write, .mem_read,
		.mem_rdata, .wb_en, .wb_reg, .wb_data, .kernel_mode
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			abort_run("timeout: the program did not run to its end within the cycle limit");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [`MIPS_XLEN-1:0] exp, act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	task automatic check_reg(input string name, input logic [4:0] exp, act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act));
	endtask

	// the feedback taps follow x^32 + x^22 + x^2 + x + 1.
	function automatic word_t take_bits(input int n);
		word_t bits;
		logic  fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[`MIPS_XLEN-2:0], fb};
		end
		return bits;
	endfunction

	// kind selects 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 signed less-than, 6 load upper.
	function automatic word_t alu_rule(input int kind, input word_t a, b);
		case (kind)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return {b[15:0], 16'h0000};
		endcase
	endfunction

	task automatic emit(input word_t ins, input logic wen, input logic [4:0] wreg,
			input word_t wdata, input logic mw, input word_t maddr, input word_t mwdata,
			input word_t next_pc);
		step_t s;
		if (imem_used[model_pc[7:2]] && imem[model_pc[7:2]] !== ins)
			abort_run("the program places two different instructions at one address");
		imem[model_pc[7:2]] = ins;
		imem_used[model_pc[7:2]] = 1'b1;
		s.pc = model_pc;
		s.wb_en = wen;
		s.wb_reg = wreg;
		s.wb_data = wdata;
		s.mem_write = mw;
		// only lw reads the data port.
		s.mem_read = (ins[31:26] == mips_pkg::LW);
		s.mem_addr = maddr;
		s.mem_wdata = mwdata;
		s.kernel_mode = model_km;
		steps.push_back(s);
		if (wen && wreg != 5'd0)
			model_regs[wreg] = wdata;
		model_pc = next_pc;
	endtask

	task automatic emit_imm(input logic [5:0] op, input int kind, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		word_t ext;
		ext = (kind >= 2 && kind <= 4) ? {16'h0000, imm} : {{16{imm[15]}}, imm};
		emit({op, rs, rt, imm}, 1'b1, rt, alu_rule(kind, model_regs[rs], ext), 1'b0, '0, '0,
			model_pc + 4);
	endtask

	task automatic emit_reg(input logic [5:0] funct, input int kind,
			input logic [4:0] rs, rt, rd);
		emit({6'h00, rs, rt, rd, 5'h00, funct}, 1'b1, rd,
			alu_rule(kind, model_regs[rs], model_regs[rt]), 1'b0, '0, '0, model_pc + 4);
	endtask

	task automatic emit_branch(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] off);
		logic taken;
		taken = (op == mips_pkg::BEQ) == (model_regs[rs] == model_regs[rt]);
		emit({op, rs, rt, off}, 1'b0, '0, '0, 1'b0, '0, '0,
			taken ? model_pc + 4 + {{14{off[15]}}, off, 2'b00} : model_pc + 4);
	endtask

	task automatic emit_jump(input logic [5:0] op, input word_t dest);
		word_t link;
		link = model_pc + 4;
		emit({op, dest[27:2]}, op == mips_pkg::JAL, 5'd31, link, 1'b0, '0, '0,
			{link[31:28], dest[27:2], 2'b00});
	endtask

	task automatic emit_trap(input word_t ins, input logic [4:0] cause);
		word_t at;
		at = model_pc;
		emit(ins, 1'b0, '0, '0, 1'b0, '0, '0, `MIPS_EXC_VECTOR);
		model_epc = at;
		model_cause = cause;
		model_km = 1'b1;
	endtask

	// the handler reads cause and EPC, steps EPC past the trapping word and returns.
	task automatic emit_handler();
		emit({mips_pkg::MFC0, 5'd0, 5'd26, 5'd13, 11'h0}, 1'b1, 5'd26,
			{25'h0, model_cause, 2'b00}, 1'b0, '0, '0, model_pc + 4);
		emit({mips_pkg::MFC0, 5'd0, 5'd27, 5'd14, 11'h0}, 1'b1, 5'd27, model_epc,
			1'b0, '0, '0, model_pc + 4);
		emit_imm(mips_pkg::ADDI, 0, 5'd27, 5'd27, 16'h0004);
		emit({mips_pkg::MTC0, 5'd0, 5'd27, 5'd14, 11'h0}, 1'b0, '0, '0, 1'b0, '0, '0,
			model_pc + 4);
		model_epc = model_regs[27];
		emit({mips_pkg::ERET, 26'h0}, 1'b0, '0, '0, 1'b0, '0, '0, model_epc);
		model_km = 1'b0;
	endtask

	task automatic build_program();
		logic [5:0] i_ops [6];
		logic [5:0] r_fns [6];
		int         i_kind [6];
		word_t      rnd;
		i_ops = '{mips_pkg::ADDI, mips_pkg::ANDI, mips_pkg::ORI, mips_pkg::XORI,
			mips_pkg::SLTI, mips_pkg::LUI};
		i_kind = '{0, 2, 3, 4, 5, 6};
		r_fns = '{mips_pkg::ADD, mips_pkg::SUB, mips_pkg::AND, mips_pkg::OR,
			mips_pkg::XOR, mips_pkg::SLT};
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'hfc00_0000 | i;
			imem_used[i] = 1'b0;
			dmem[i] = 32'hda7a_0000 | i;
		end
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		model_pc = `MIPS_RESET_PC;
		model_km = 1'b1;
		for (int k = 0; k < 6; k++) begin
			rnd = take_bits(16);
			emit_imm(i_ops[k], i_kind[k], 5'(k), 5'(k + 1), rnd[15:0]);
		end
		for (int k = 0; k < 6; k++)
			emit_reg(r_fns[k], k, 5'(k + 1), 5'(6 - k), 5'(k + 7));
		emit_imm(mips_pkg::ADDI, 0, 5'd1, 5'd0, 16'h0005);
		emit_reg(mips_pkg::ADD, 0, 5'd0, 5'd2, 5'd13);
		emit_imm(mips_pkg::ADDI, 0, 5'd0, 5'd14, 16'h0040);
		emit({mips_pkg::SW, 5'd14, 5'd3, 16'h0008}, 1'b0, '0, '0, 1'b1,
			model_regs[14] + 8, model_regs[3], model_pc + 4);
		emit({mips_pkg::LW, 5'd14, 5'd15, 16'h0008}, 1'b1, 5'd15, model_regs[3], 1'b0,
			model_regs[14] + 8, '0, model_pc + 4);
		emit_branch(mips_pkg::BEQ, 5'd15, 5'd3, 16'h0001);
		emit_branch(mips_pkg::BNE, 5'd15, 5'd3, 16'h0005);
		emit_branch(mips_pkg::BNE, 5'd14, 5'd0, 16'h0001);
		emit_branch(mips_pkg::BEQ, 5'd14, 5'd0, 16'h0003);
		emit_jump(mips_pkg::J, 32'h0000_0064);
		emit_jump(mips_pkg::JAL, 32'h0000_00a0);
		emit_imm(mips_pkg::ADDI, 0, 5'd0, 5'd16, 16'h00b0);
		emit({6'h00, 5'd16, 15'h0, mips_pkg::JR}, 1'b0, '0, '0, 1'b0, '0, '0,
			model_regs[16]);
		// drop to user mode, then trap three ways.
		emit({mips_pkg::MTC0, 5'd0, 5'd0, 5'd12, 11'h0}, 1'b0, '0, '0, 1'b0, '0, '0,
			model_pc + 4);
		model_km = 1'b0;
		emit_trap({mips_pkg::MFC0, 5'd0, 5'd17, 5'd12, 11'h0}, mips_pkg::CAUSE_RI);
		emit_handler();
		emit_trap({6'h00, 20'h0, mips_pkg::SYSCALL}, mips_pkg::CAUSE_SYS);
		emit_handler();
		emit_trap(32'h7c00_0000, mips_pkg::CAUSE_RI);
		emit_handler();
		emit_imm(mips_pkg::ADDI, 0, 5'd0, 5'd18, 16'h0123);
	endtask

	initial begin
		step_t s;
		word_t store_word;
		word_t load_word;
		build_program();
		cycle_limit = 2 * steps.size() + 20;
		// a store and a load alternate while reset is held, and neither may reach the ports.
		store_word = {mips_pkg::SW, 5'd0, 5'd1, 16'h0010};
		load_word = {mips_pkg::LW, 5'd0, 5'd2, 16'h0010};
		arst_n = 1'b0;
		instr = store_word;
		mem_rdata = '0;
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			instr = k[0] ? store_word : load_word;
			#2;
			check_word("pc", `MIPS_RESET_PC, pc);
			check_bit("kernel_mode", 1'b1, kernel_mode);
			check_bit("wb_en", 1'b0, wb_en);
			check_bit("mem_write", 1'b0, mem_write);
			check_bit("mem_read", 1'b0, mem_read);
		end
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			instr = imem[pc[7:2]];
			#1 mem_rdata = dmem[mem_addr[7:2]];
			#1;
			check_word("pc", s.pc, pc);
			check_bit("kernel_mode", s.kernel_mode, kernel_mode);
			check_bit("wb_en", s.wb_en, wb_en);
			if (s.wb_en) begin
				check_reg("wb_reg", s.wb_reg, wb_reg);
				check_word("wb_data", s.wb_data, wb_data);
			end
			check_bit("mem_write", s.mem_write, mem_write);
			check_bit("mem_read", s.mem_read, mem_read);
			if (s.mem_write || s.mem_read)
				check_word("mem_addr", s.mem_addr, mem_addr);
			if (s.mem_write) begin
				check_word("mem_wdata", s.mem_wdata, mem_wdata);
				dmem[mem_addr[7:2]] = mem_wdata;
			end
			@(negedge clk);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module alu (
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  mips_pkg::alu_op_e     op,
	output logic [`MIPS_XLEN-1:0] result,
	output logic                  zero
);

	localparam int HALF = `MIPS_XLEN / 2;

	logic [`MIPS_XLEN-1:0] sum;
	logic [`MIPS_XLEN-1:0] diff;
	logic                  less;

	assign sum  = a + b;
	assign diff = a - b;

	// signed compare, as slt and slti need.
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: begin
				result = sum;
			end
			mips_pkg::ALU_SUB: begin
				result = diff;
			end
			mips_pkg::ALU_AND: begin
				result = a & b;
			end
			mips_pkg::ALU_OR: begin
				result = a | b;
			end
			mips_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			mips_pkg::ALU_SLT: begin
				result = {{(`MIPS_XLEN-1){1'b0}}, less};
			end
			mips_pkg::ALU_LUI: begin
				result = {b[HALF-1:0], {HALF{1'b0}}};
			end
			default: begin
				result = sum;
			end
		endcase
	end

	// beq and bne compare the operands directly.
	assign zero = (diff == '0);

endmodule

`default_nettype wire

// ==== hw/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control (
	input  mips_pkg::opcode_e opcode,
	input  mips_pkg::funct_e  funct,
	input  logic              cpu_mode,
	output logic              regwrite,
	output logic              memtoreg,
	output logic              memread,
	output logic              memwrite,
	output logic              isbranch,
	output logic              isjump,
	output logic              jumpdst,
	output logic              islink,
	output logic              regdst,
	output mips_pkg::alu_op_e alu_op,
	output logic              alu_src_imm,
	output logic              cp0_read,
	output logic              cp0_write,
	output logic              exc_ri,
	output logic              exc_sys,
	output logic              exc_ret
);

	// every strobe starts low, each opcode raises only what it needs.
	always_comb begin
		regwrite    = 1'b0;
		memtoreg    = 1'b0;
		memread     = 1'b0;
		memwrite    = 1'b0;
		isbranch    = 1'b0;
		isjump      = 1'b0;
		jumpdst     = 1'b0;
		islink      = 1'b0;
		regdst      = 1'b0;
		alu_op      = mips_pkg::ALU_ADD;
		alu_src_imm = 1'b0;
		cp0_read    = 1'b0;
		cp0_write   = 1'b0;
		exc_ri      = 1'b0;
		exc_sys     = 1'b0;
		exc_ret     = 1'b0;

		case (opcode)
			mips_pkg::RTYPE: begin
				case (funct)
					mips_pkg::JR: begin
						isjump  = 1'b1;
						jumpdst = 1'b1;
					end
					mips_pkg::SYSCALL: exc_sys = 1'b1;
					mips_pkg::ADD,
					mips_pkg::SUB,
					mips_pkg::AND,
					mips_pkg::OR,
					mips_pkg::XOR,
					mips_pkg::SLT: begin
						regwrite = 1'b1;
						regdst   = 1'b1;
						case (funct)
							mips_pkg::SUB: alu_op = mips_pkg::ALU_SUB;
							mips_pkg::AND: alu_op = mips_pkg::ALU_AND;
							mips_pkg::OR:  alu_op = mips_pkg::ALU_OR;
							mips_pkg::XOR: alu_op = mips_pkg::ALU_XOR;
							mips_pkg::SLT: alu_op = mips_pkg::ALU_SLT;
							default:       alu_op = mips_pkg::ALU_ADD;
						endcase
					end
					default: exc_ri = 1'b1;
				endcase
			end
			mips_pkg::ADDI,
			mips_pkg::ANDI,
			mips_pkg::ORI,
			mips_pkg::XORI,
			mips_pkg::SLTI,
			mips_pkg::LUI: begin
				regwrite    = 1'b1;
				alu_src_imm = 1'b1;
				case (opcode)
					mips_pkg::ANDI: alu_op = mips_pkg::ALU_AND;
					mips_pkg::ORI:  alu_op = mips_pkg::ALU_OR;
					mips_pkg::XORI: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::SLTI: alu_op = mips_pkg::ALU_SLT;
					mips_pkg::LUI:  alu_op = mips_pkg::ALU_LUI;
					default:        alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			mips_pkg::LW: begin
				regwrite    = 1'b1;
				memtoreg    = 1'b1;
				memread     = 1'b1;
				alu_src_imm = 1'b1;
			end
			mips_pkg::SW: begin
				memwrite    = 1'b1;
				alu_src_imm = 1'b1;
			end
			mips_pkg::BEQ,
			mips_pkg::BNE: begin
				isbranch = 1'b1;
				alu_op   = mips_pkg::ALU_SUB;
			end
			mips_pkg::J: isjump = 1'b1;
			mips_pkg::JAL: begin
				isjump   = 1'b1;
				islink   = 1'b1;
				regwrite = 1'b1;
			end
			// privileged instructions act only in kernel mode.
			mips_pkg::MFC0: begin
				exc_ri   = ~cpu_mode;
				regwrite = cpu_mode;
				cp0_read = cpu_mode;
			end
			mips_pkg::MTC0: begin
				exc_ri    = ~cpu_mode;
				cp0_write = cpu_mode;
			end
			mips_pkg::ERET: begin
				exc_ri  = ~cpu_mode;
				exc_ret = cpu_mode;
			end
			default: exc_ri = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/cp0.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module cp0 (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   exc_take,
	input  mips_pkg::exc_cause_e   exc_cause,
	input  logic [`MIPS_XLEN-1:0]  exc_pc,
	input  logic                   exc_ret,
	input  logic                   wr_en,
	input  mips_pkg::cp0_reg_e     reg_sel,
	input  logic [`MIPS_XLEN-1:0]  wr_data,
	output logic [`MIPS_XLEN-1:0]  rd_data,
	output logic [`MIPS_XLEN-1:0]  epc,
	output logic                   kernel_mode
);

	logic                  mode_q;
	logic [4:0]            cause_q;
	logic [`MIPS_XLEN-1:0] epc_q;

	// exception entry wins over eret and over an mtc0 in the same cycle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode_q  <= 1'b1;
			cause_q <= '0;
			epc_q   <= '0;
		end else if (exc_take) begin
			mode_q  <= 1'b1;
			cause_q <= exc_cause;
			epc_q   <= exc_pc;
		end else if (exc_ret) begin
			mode_q <= 1'b0;
		end else if (wr_en) begin
			case (reg_sel)
				mips_pkg::CP0_STATUS: mode_q  <= wr_data[0];
				mips_pkg::CP0_CAUSE:  cause_q <= wr_data[6:2];
				mips_pkg::CP0_EPC:    epc_q   <= wr_data;
				default: begin
				end
			endcase
		end
	end

	// the cause code sits in bits 6:2, as in the exccode field.
	always_comb begin
		case (reg_sel)
			mips_pkg::CP0_STATUS: rd_data = {{(`MIPS_XLEN-1){1'b0}}, mode_q};
			mips_pkg::CP0_CAUSE:  rd_data = {{(`MIPS_XLEN-7){1'b0}}, cause_q, 2'b00};
			mips_pkg::CP0_EPC:    rd_data = epc_q;
			default:              rd_data = '0;
		endcase
	end

	assign epc         = epc_q;
	assign kernel_mode = mode_q;

endmodule

`default_nettype wire

// ==== hw/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data path and address width.
`define MIPS_XLEN 32

// number of general purpose registers, register 0 reads as zero.
`define MIPS_REG_COUNT 32

// fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

// all exceptions enter here.
`define MIPS_EXC_VECTOR 32'h0000_0080

`endif

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic [`MIPS_XLEN-1:0] pc,
	input  logic [`MIPS_XLEN-1:0] instr,
	output logic [`MIPS_XLEN-1:0] mem_addr,
	output logic [`MIPS_XLEN-1:0] mem_wdata,
	output logic                  mem_write,
	output logic                  mem_read,
	input  logic [`MIPS_XLEN-1:0] mem_rdata,
	output logic                  wb_en,
	output logic [4:0]            wb_reg,
	output logic [`MIPS_XLEN-1:0] wb_data,
	output logic                  kernel_mode
);

	mips_pkg::opcode_e     opcode;
	mips_pkg::funct_e      funct;
	logic [4:0]            rs, rt, rd;
	logic [15:0]           imm;
	logic [25:0]           target;

	logic                  regwrite, memtoreg, memread, memwrite;
	logic                  isbranch, isjump, jumpdst, islink, regdst;
	logic                  alu_src_imm, cp0_read, cp0_write;
	logic                  exc_ri, exc_sys, exc_ret, exc_take;
	mips_pkg::alu_op_e     alu_op;

	logic [`MIPS_XLEN-1:0] rs_data, rt_data, imm_ext, alu_b, alu_result;
	logic                  alu_zero;
	logic [`MIPS_XLEN-1:0] cp0_rd_data, epc;
	logic [`MIPS_XLEN-1:0] pc_plus4, branch_target, jump_target, pc_next;
	logic                  branch_taken, zero_ext;

	assign opcode = mips_pkg::opcode_e'(instr[31:26]);
	assign funct  = mips_pkg::funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];
	assign target = instr[25:0];

	control control_inst (
		.opcode, .funct, .cpu_mode(kernel_mode),
		.regwrite, .memtoreg, .memread, .memwrite, .isbranch, .isjump, .jumpdst,
		.islink, .regdst, .alu_op, .alu_src_imm, .cp0_read, .cp0_write,
		.exc_ri, .exc_sys, .exc_ret
	);

	assign exc_take = exc_ri | exc_sys;

	// logical immediates are zero extended, all others sign extended.
	assign zero_ext = (opcode == mips_pkg::ANDI) || (opcode == mips_pkg::ORI) ||
			(opcode == mips_pkg::XORI);
	assign imm_ext  = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm} :
			{{(`MIPS_XLEN-16){imm[15]}}, imm};
	assign alu_b    = alu_src_imm ? imm_ext : rt_data;

	reg_file reg_file_inst (
		.clk, .arst_n, .rs_addr(rs), .rt_addr(rt),
		.wr_en(wb_en), .wr_addr(wb_reg), .wr_data(wb_data),
		.rs_data, .rt_data
	);

	alu alu_inst (
		.a(rs_data), .b(alu_b), .op(alu_op), .result(alu_result), .zero(alu_zero)
	);

	cp0 cp0_inst (
		.clk, .arst_n, .exc_take,
		.exc_cause(exc_sys ? mips_pkg::CAUSE_SYS : mips_pkg::CAUSE_RI),
		.exc_pc(pc), .exc_ret, .wr_en(cp0_write),
		.reg_sel(mips_pkg::cp0_reg_e'(rd)), .wr_data(rt_data),
		.rd_data(cp0_rd_data), .epc, .kernel_mode
	);

	// an excepting instruction leaves registers and memory untouched.
	assign wb_en     = arst_n & regwrite & ~exc_take;
	assign mem_write = arst_n & memwrite & ~exc_take;
	assign mem_read  = arst_n & memread & ~exc_take;
	assign mem_addr  = alu_result;
	assign mem_wdata = rt_data;

	assign wb_reg  = islink ? 5'd31 : (regdst ? rd : rt);
	assign wb_data = islink   ? pc_plus4 :
			cp0_read ? cp0_rd_data :
			memtoreg ? mem_rdata : alu_result;

	assign pc_plus4      = pc + `MIPS_XLEN'd4;
	assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
	assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], target, 2'b00};
	assign branch_taken  = isbranch & ((opcode == mips_pkg::BNE) ? ~alu_zero : alu_zero);

	always_comb begin
		if (exc_take) begin
			pc_next = `MIPS_EXC_VECTOR;
		end else if (exc_ret) begin
			pc_next = epc;
		end else if (isjump && jumpdst) begin
			pc_next = rs_data;
		end else if (isjump) begin
			pc_next = jump_target;
		end else if (branch_taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `MIPS_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// primary opcodes. The coprocessor 0 instructions get opcodes of their own.
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		SLTI  = 6'h0a,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		MFC0  = 6'h10,
		MTC0  = 6'h11,
		ERET  = 6'h12,
		LW    = 6'h23,
		SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		JR      = 6'h08,
		SYSCALL = 6'h0c,
		ADD     = 6'h20,
		SUB     = 6'h22,
		AND     = 6'h24,
		OR      = 6'h25,
		XOR     = 6'h26,
		SLT     = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [4:0] {
		CAUSE_SYS = 5'd8,
		CAUSE_RI  = 5'd10
	} exc_cause_e;

	typedef enum logic [4:0] {
		CP0_STATUS = 5'd12,
		CP0_CAUSE  = 5'd13,
		CP0_EPC    = 5'd14
	} cp0_reg_e;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [4:0]            rs_addr,
	input  logic [4:0]            rt_addr,
	input  logic                  wr_en,
	input  logic [4:0]            wr_addr,
	input  logic [`MIPS_XLEN-1:0] wr_data,
	output logic [`MIPS_XLEN-1:0] rs_data,
	output logic [`MIPS_XLEN-1:0] rt_data
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// register 0 is never written, so it keeps the zero it gets at reset.
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+hw
hw/mips_pkg.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/cp0.sv
hw/mips_core.sv
bench/mips_core_tb.sv
